/* verilog/fetch_defines.svh */
// Widths, lane count and RV32I opcodes for the fetch stage
// One cache word is assumed to hold exactly two instructions

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address and instruction width
`define XLEN        32

// Instructions presented per cycle
`define FETCH_LANES 4

// One word of the two-word cache return
`define CACHE_WORD  64

// Major opcodes seen by predecode
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

`endif

/* verilog/fetch_pkg.sv */
// Types shared by the fetch stage and the instruction buffer side
// Field layouts follow the RV32I base encodings
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

    // J-type layout, msb first
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    // B-type layout, msb first
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef union packed {
        logic [`XLEN-1:0] raw;
        j_fields_t        j;
        b_fields_t        b;
    } rv_insn_u;

    typedef struct packed {
        logic             jal;
        logic             jalr;
        logic             cond_branch;
        logic [`XLEN-1:0] target;      // JAL or branch target, else zero
    } predecode_t;

    typedef struct packed {
        logic             valid;
        rv_insn_u         insn;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] npc;
        logic [`XLEN-1:0] pred_pc;
        predecode_t       predecode;
    } fetch_lane_t;

    typedef fetch_lane_t [`FETCH_LANES-1:0] fetch_bundle_t;

    // Strobe from execute that ends a branch stall
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } resolve_t;

    typedef logic [$clog2(`FETCH_LANES+1)-1:0] taken_t;   // 0 to FETCH_LANES

endpackage

`default_nettype wire

/* verilog/lane_predecode.sv */
// Predecode of one RV32 word for JAL, JALR and the six conditional branches
// JALR gets no target since its base register is unknown here
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module lane_predecode (
    input  fetch_pkg::rv_insn_u   insn,
    input  logic                  present,    // Word came back from the cache
    input  logic [`XLEN-1:0]      pc,
    output fetch_pkg::predecode_t info
);

    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] b_imm;
    logic             funct3_ok;

    // Sign-extended immediates, one per view of the word
    assign j_imm = {{(`XLEN-20){insn.j.imm20}},
                    insn.j.imm19_12,
                    insn.j.imm11,
                    insn.j.imm10_1,
                    1'b0};

    assign b_imm = {{(`XLEN-12){insn.b.imm12}},
                    insn.b.imm11,
                    insn.b.imm10_5,
                    insn.b.imm4_1,
                    1'b0};

    // funct3 values 010 and 011 are not branches
    assign funct3_ok = (insn.b.funct3[2:1] != 2'b01);

    always_comb begin
        info = '0;
        if (present) begin
            case (insn.j.opcode)    // Opcode sits in the same bits in both views
                `OPC_JAL: begin
                    info.jal    = 1'b1;
                    info.target = pc + j_imm;
                end
                `OPC_JALR: begin
                    info.jalr = 1'b1;
                end
                `OPC_BRANCH: begin
                    if (funct3_ok) begin
                        info.cond_branch = 1'b1;
                        info.target      = pc + b_imm;
                    end
                end
                default: begin
                    info = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_window.sv */
// Aligns the two-word cache return to the fetch PC and builds the lane bundle
// With pc bit 2 set only three lanes can be filled
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_window (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [1:0][`CACHE_WORD-1:0]     data_read,
    input  logic [1:0]                      return_valid,
    input  logic [`XLEN-1:0]                npc,          // Address of this cycle's read
    input  logic [`XLEN-1:0]                pc,           // Address of the registered words
    input  logic                            stall,
    input  fetch_pkg::resolve_t             resolve,
    output fetch_pkg::fetch_bundle_t        bundle
);
    import fetch_pkg::*;

    logic       [`XLEN-1:0]        lo0;
    logic       [`XLEN-1:0]        hi0;
    logic       [`XLEN-1:0]        lo1;
    logic       [`XLEN-1:0]        hi1;
    rv_insn_u   [`FETCH_LANES-1:0] word_d;
    logic       [`FETCH_LANES-1:0] present_d;
    rv_insn_u   [`FETCH_LANES-1:0] word;
    logic       [`FETCH_LANES-1:0] present;
    predecode_t [`FETCH_LANES-1:0] info;
    logic       [`XLEN-1:0]        lane_pc [`FETCH_LANES];
    logic       [`FETCH_LANES-1:0] is_ctrl;
    logic       [`FETCH_LANES-1:0] lane_valid;

    assign lo0 = data_read[0][`XLEN-1:0];
    assign hi0 = data_read[0][2*`XLEN-1:`XLEN];
    assign lo1 = data_read[1][`XLEN-1:0];
    assign hi1 = data_read[1][2*`XLEN-1:`XLEN];

    // Shift the return down one slot when the read starts on the upper half
    always_comb begin
        word_d    = '0;
        present_d = '0;
        if (return_valid[0]) begin
            present_d[0]  = 1'b1;
            present_d[1]  = npc[2] ? return_valid[1] : 1'b1;
            word_d[0].raw = npc[2] ? hi0 : lo0;
            word_d[1].raw = npc[2] ? lo1 : hi0;
        end
        if (return_valid[1]) begin
            present_d[2]  = 1'b1;
            present_d[3]  = !npc[2];            // Nothing left for lane 3
            word_d[2].raw = npc[2] ? hi1 : lo1;
            word_d[3].raw = npc[2] ? '0 : hi1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            present <= '0;
        end else begin
            present <= present_d;
        end
    end

    always_ff @(posedge clock) begin
        word <= word_d;
    end

    for (genvar k = 0; k < `FETCH_LANES; k++) begin : g_lane
        assign lane_pc[k] = pc + 4 * k;

        lane_predecode lane_predecode_i (
            .insn    (word[k]),
            .present (present[k]),
            .pc      (lane_pc[k]),
            .info    (info[k])
        );
    end

    // Valid chain stops after the first control instruction
    always_comb begin
        for (int k = 0; k < `FETCH_LANES; k++) begin
            is_ctrl[k]    = info[k].jal | info[k].jalr | info[k].cond_branch;
            lane_valid[k] = (|word[k].raw) & present[k] & !stall & !resolve.valid;
        end
        for (int k = 1; k < `FETCH_LANES; k++) begin
            lane_valid[k] = lane_valid[k] & lane_valid[k-1] & !is_ctrl[k-1];
        end
        lane_valid[`FETCH_LANES-1] = lane_valid[`FETCH_LANES-1] & !pc[2];
    end

    always_comb begin
        for (int k = 0; k < `FETCH_LANES; k++) begin
            bundle[k].valid     = lane_valid[k];
            bundle[k].insn      = word[k];
            bundle[k].pc        = lane_pc[k];
            bundle[k].npc       = lane_pc[k] + 4;
            bundle[k].predecode = info[k];
            if (info[k].jal) begin
                bundle[k].pred_pc = info[k].target;
            end else if (info[k].cond_branch) begin
                bundle[k].pred_pc = lane_pc[k] + 4;     // Predicted not taken
            end else begin
                bundle[k].pred_pc = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/branch_hold.sv */
// Stall flag for a taken JALR or conditional branch
// Only a resolve strobe clears it, there is no timeout
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module branch_hold (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_pkg::taken_t        insn_taken,
    input  fetch_pkg::fetch_bundle_t bundle,
    input  fetch_pkg::resolve_t      resolve,
    output logic                     stall
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`FETCH_LANES);

    logic [IDX_W-1:0] last_idx;
    fetch_lane_t      last_lane;
    logic             any_taken;
    logic             hold_set;

    // Youngest lane the buffer accepted
    assign last_idx  = IDX_W'(insn_taken - 1'b1);
    assign last_lane = bundle[last_idx];
    assign any_taken = (insn_taken != '0);

    // Target of JALR and of branches is unknown until execute
    assign hold_set = any_taken & last_lane.valid &
                      (last_lane.predecode.jalr | last_lane.predecode.cond_branch);

    always_ff @(posedge clock) begin
        if (reset) begin
            stall <= 1'b0;
        end else if (resolve.valid) begin
            stall <= 1'b0;      // Wins over a set in the same cycle
        end else if (hold_set) begin
            stall <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/pc_sequencer.sv */
// PC register and next-PC select for the fetch stage
// Reads are always aligned to a 64-bit cache word
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_sequencer (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_pkg::taken_t        insn_taken,
    input  fetch_pkg::fetch_bundle_t bundle,
    input  logic                     stall,
    input  fetch_pkg::resolve_t      resolve,
    output logic [`XLEN-1:0]         pc,
    output logic [`XLEN-1:0]         npc,
    output logic [`XLEN-1:0]         read_addr,
    output logic                     read_valid
);
    import fetch_pkg::*;

    localparam int IDX_W  = $clog2(`FETCH_LANES);
    localparam int PAD_W  = `XLEN - $bits(taken_t) - 2;

    logic [IDX_W-1:0] last_idx;
    fetch_lane_t      last_lane;
    logic             jal_taken;
    logic [`XLEN-1:0] seq_pc;

    assign last_idx  = IDX_W'(insn_taken - 1'b1);
    assign last_lane = bundle[last_idx];
    assign jal_taken = (insn_taken != '0) & last_lane.predecode.jal;

    // Four bytes per accepted instruction
    assign seq_pc = pc + {{PAD_W{1'b0}}, insn_taken, 2'b00};

    always_comb begin
        if (resolve.valid) begin
            npc = resolve.target;
        end else if (stall) begin
            npc = pc;                           // Re-read the same word
        end else if (jal_taken) begin
            npc = last_lane.predecode.target;
        end else begin
            npc = seq_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= npc;
        end
    end

    assign read_addr  = {npc[`XLEN-1:3], 3'b000};
    assign read_valid = !stall;

endmodule

`default_nettype wire

/* verilog/insn_fetch.sv */
// Four-wide RV32 fetch stage between the instruction cache and the buffer
// Cache data must come back in the same cycle as the read request
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module insn_fetch (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [1:0][`CACHE_WORD-1:0] data_read,
    input  logic [1:0]                  return_valid,
    input  fetch_pkg::taken_t           insn_taken,   // Lanes the buffer accepted
    input  fetch_pkg::resolve_t         resolve,
    output fetch_pkg::fetch_bundle_t    bundle,
    output logic [`XLEN-1:0]            read_addr,
    output logic                        read_valid
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] npc;
    logic             stall;

    fetch_window fetch_window_i (
        .clock        (clock),
        .reset        (reset),
        .data_read    (data_read),
        .return_valid (return_valid),
        .npc          (npc),
        .pc           (pc),
        .stall        (stall),
        .resolve      (resolve),
        .bundle       (bundle)
    );

    branch_hold branch_hold_i (
        .clock      (clock),
        .reset      (reset),
        .insn_taken (insn_taken),
        .bundle     (bundle),
        .resolve    (resolve),
        .stall      (stall)
    );

    pc_sequencer pc_sequencer_i (
        .clock      (clock),
        .reset      (reset),
        .insn_taken (insn_taken),
        .bundle     (bundle),
        .stall      (stall),
        .resolve    (resolve),
        .pc         (pc),
        .npc        (npc),
        .read_addr  (read_addr),
        .read_valid (read_valid)
    );

endmodule

`default_nettype wire

/* verification/insn_fetch_tb.sv */
// Runs from the project root and reads verification/fetch_stim.txt
// Cache model answers in the same cycle from a 64-word image that wraps
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module insn_fetch_tb;
    import fetch_pkg::*;

    localparam int PERIOD     = 40;
    localparam int PROG_WORDS = 64;
    localparam int VEC_BASE   = 64;     // Vector count word with the rows after it
    localparam int VEC_COLS   = 7;
    localparam int STIM_SIZE  = 512;
    localparam int MAX_VECS   = (STIM_SIZE - VEC_BASE - 1) / VEC_COLS;

    logic                        clock = 1'b0;
    logic                        reset = 1'b1;
    logic [1:0][`CACHE_WORD-1:0] data_read;
    logic [1:0]                  return_valid;
    taken_t                      insn_taken = '0;
    resolve_t                    resolve = '0;
    fetch_bundle_t               bundle;
    logic [`XLEN-1:0]            read_addr;
    logic                        read_valid;

    logic [`XLEN-1:0] stim [STIM_SIZE];
    logic [`XLEN-1:0] prog [PROG_WORDS];
    logic [5:0]       word_idx;
    int               vec_count = 0;
    logic             loaded = 1'b0;

    always #(PERIOD / 2) clock = ~clock;

    insn_fetch insn_fetch_i (
        .clock        (clock),
        .reset        (reset),
        .data_read    (data_read),
        .return_valid (return_valid),
        .insn_taken   (insn_taken),
        .resolve      (resolve),
        .bundle       (bundle),
        .read_addr    (read_addr),
        .read_valid   (read_valid)
    );

    // Same-cycle cache returning two 64-bit words from the aligned address
    assign word_idx     = read_addr[7:2];
    assign data_read[0] = {prog[word_idx + 6'd1], prog[word_idx]};
    assign data_read[1] = {prog[word_idx + 6'd3], prog[word_idx + 6'd2]};
    assign return_valid = {read_valid, read_valid};

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] time %0t ns: %s expected %h got %h", $time, signal, expected, actual);
        abort_run();
    endtask

    task automatic check_lane(input string name, input fetch_lane_t expected,
                              input fetch_lane_t actual);
        if (actual.valid !== expected.valid) begin
            report_mismatch({name, ".valid"}, 32'(expected.valid), 32'(actual.valid));
        end
        if (actual.pc !== expected.pc) begin
            report_mismatch({name, ".pc"}, expected.pc, actual.pc);
        end
        if (actual.npc !== expected.npc) begin
            report_mismatch({name, ".npc"}, expected.npc, actual.npc);
        end
        // Word and prediction only mean something on a valid lane
        if (expected.valid) begin
            if (actual.insn.raw !== expected.insn.raw) begin
                report_mismatch({name, ".insn"}, expected.insn.raw, actual.insn.raw);
            end
            if (actual.pred_pc !== expected.pred_pc) begin
                report_mismatch({name, ".pred_pc"}, expected.pred_pc, actual.pred_pc);
            end
        end
    endtask

    task automatic check_count(input string name, input taken_t expected, input taken_t actual);
        if (actual !== expected) begin
            report_mismatch(name, 32'(expected), 32'(actual));
        end
    endtask

    task automatic check_addr(input string name, input logic [`XLEN-1:0] expected,
                              input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            report_mismatch(name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_mismatch(name, 32'(expected), 32'(actual));
        end
    endtask

    function automatic taken_t count_valid(input fetch_bundle_t lanes);
        taken_t total;
        total = '0;
        for (int k = 0; k < `FETCH_LANES; k++) begin
            total = total + taken_t'(lanes[k].valid);
        end
        return total;
    endfunction

    initial begin
        int          row;
        int          lanes;
        fetch_lane_t want;

        $readmemh("verification/fetch_stim.txt", stim);
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = stim[i];
        end
        vec_count = stim[VEC_BASE];
        loaded    = 1'b1;
        if (vec_count < 1 || vec_count > MAX_VECS) begin
            $display("Stimulus file holds no usable vector count (%0d)", vec_count);
            abort_run();
        end

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int n = 0; n < vec_count; n++) begin
            row = VEC_BASE + 1 + n * VEC_COLS;
            if (n > 0) begin
                @(negedge clock);
            end
            if (stim[row] > stim[row + 4]) begin
                $display("Vector %0d takes more instructions than the bundle offers", n);
                abort_run();
            end
            insn_taken     = taken_t'(stim[row]);
            resolve.valid  = stim[row + 1][0];
            resolve.target = stim[row + 2];
            #1;                                     // Let the lane valids settle

            // Count first, lane checks then catch a valid bit in the wrong place
            check_count("valid lane count", taken_t'(stim[row + 4]), count_valid(bundle));

            lanes = int'(stim[row + 4]);
            for (int k = 0; k < `FETCH_LANES; k++) begin
                want          = '0;
                want.valid    = (k < lanes);
                want.pc       = stim[row + 3] + 32'(4 * k);
                want.npc      = want.pc + 32'd4;
                want.insn.raw = prog[want.pc[7:2]];
                want.pred_pc  = (k == lanes - 1) ? stim[row + 6] : '0;
                check_lane($sformatf("bundle[%0d]", k), want, bundle[k]);
            end
            check_flag("read_valid", stim[row + 5][0], read_valid);

            // This cycle's read is next cycle's pc aligned to the cache word
            if (n + 1 < vec_count) begin
                check_addr("read_addr", {stim[row + VEC_COLS + 3][31:3], 3'b000}, read_addr);
            end
        end

        $display("Simulation passed");
        $finish;
    end

    // Watchdog sized from the vector count plus reset
    initial begin
        wait (loaded);
        repeat (vec_count + 3 + 20) @(posedge clock);
        $display("Timeout: the run hung before all vectors were checked");
        abort_run();
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/lane_predecode.sv
verilog/fetch_window.sv
verilog/branch_hold.sv
verilog/pc_sequencer.sv
verilog/insn_fetch.sv
verification/insn_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the fetch stage testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module insn_fetch_tb \
    -Mdir obj_dir \
    -o insn_fetch_sim

# The simulator exits non-zero on a failed check, the search below decides
output=$(./obj_dir/insn_fetch_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi

/* verification/fetch_stim.txt */
// Program image at @00: 64 instruction words, eight per line, word i at byte address 4*i
// Vectors at @40: the vector count, then one row per cycle with the columns
// taken resolve_valid resolve_target lane0_pc valid_lanes read_valid last_valid_pred_pc
@00
00000013 00100013 00200013 00300013 00400013 00500013 00600013 00700013
00800013 00900013 00A00013 054000EF 00C00013 00D00013 00E00013 00F00013
01000013 01100013 01200013 01300013 01400013 01500013 00000000 01700013
01800013 01900013 01A00013 01B00013 01C00013 01D00013 01E00013 01F00013
02000013 02100013 04208063 02300013 02400013 02500013 02600013 02700013
02800013 02900013 02A00013 00008067 02C00013 02D00013 02E00013 02F00013
03000013 03100013 03200013 03300013 03400013 03500013 03600013 03700013
03800013 03900013 03A00013 03B00013 03C00013 03D00013 03E00013 03F00013
@40
00000012
00000000 00000000 00000000 00000000 00000000 00000001 00000000
00000004 00000000 00000000 00000000 00000004 00000001 00000000
00000001 00000000 00000000 00000010 00000004 00000001 00000000
00000002 00000000 00000000 00000014 00000003 00000001 00000000
00000003 00000000 00000000 0000001C 00000003 00000001 00000000
00000000 00000000 00000000 00000028 00000002 00000001 00000080
00000002 00000000 00000000 00000028 00000002 00000001 00000080
00000003 00000000 00000000 00000080 00000003 00000001 0000008C
00000000 00000000 00000000 0000008C 00000000 00000000 00000000
00000000 00000000 00000000 0000008C 00000000 00000000 00000000
00000000 00000001 000000A4 0000008C 00000000 00000000 00000000
00000000 00000000 00000000 000000A4 00000000 00000001 00000000
00000003 00000000 00000000 000000A4 00000003 00000001 00000000
00000000 00000001 00000040 000000B0 00000000 00000000 00000000
00000000 00000000 00000000 00000040 00000000 00000001 00000000
00000004 00000000 00000000 00000040 00000004 00000001 00000000
00000002 00000000 00000000 00000050 00000002 00000001 00000000
00000000 00000000 00000000 00000058 00000000 00000001 00000000
